//--- dv/tb_checks.svh
//////////////////////////////////////////////////
// compare tasks for the tone sound testbench
// one task per result kind, typed like the DUT
// ports; a mismatch prints an ERR line and stops
// the run through stop_run
//////////////////////////////////////////////////

// request pulse
task automatic check_req(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("ERR time=%0t %s expected=%0b actual=%0b",
             $time, name, expected, actual);
    stop_run();
  end
endtask

// interrupt vector address
task automatic check_vec(input string name,
                         input tone_pkg::vec_addr_t expected,
                         input tone_pkg::vec_addr_t actual);
  if (actual !== expected) begin
    $display("ERR time=%0t %s expected=%03h actual=%03h",
             $time, name, expected, actual);
    stop_run();
  end
endtask

// PCM output word
task automatic check_pcm(input string name,
                         input tone_pkg::pcm_out_t expected,
                         input tone_pkg::pcm_out_t actual);
  if (actual !== expected) begin
    $display("ERR time=%0t %s expected=%03h actual=%03h",
             $time, name, expected, actual);
    stop_run();
  end
endtask

// failures that are not a wrong value
task automatic report_problem(input string what);
  $display("problem at time %0t: %s", $time, what);
  stop_run();
endtask

//--- dv/tb_tone_sound.sv
//////////////////////////////////////////////////
// testbench for the tone sound top level
// random stimulus on the falling edge, checked each
// cycle against a cycle model of the sequencer,
// divider, trigger, interrupt and DAC rules
//////////////////////////////////////////////////

module tb_tone_sound;

  localparam int CLK_PERIOD    = 8;
  localparam int PHASE_STEPS   = 8;
  localparam int RESET_CYCLES  = 8;
  localparam int QUIET_CYCLES  = 300;   // per N value
  localparam int RANGE_CYCLES  = 6000;  // per range
  localparam int RANDOM_CYCLES = 20000;
  localparam int DAC_CYCLES    = 3000;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 3 * QUIET_CYCLES + 5 * RANGE_CYCLES
                               + RANDOM_CYCLES + DAC_CYCLES;
  localparam int MODE_QUIET  = 0;
  localparam int MODE_RANGE  = 1;
  localparam int MODE_RANDOM = 2;
  localparam int MODE_DAC    = 3;

  logic                   CLK;
  logic                   reset;
  logic                   cken;
  logic                   n_load;
  tone_pkg::tone_period_t n_value;
  logic                   tone_ie;
  logic                   reti;
  logic                   da_write;
  tone_pkg::pcm_sample_t  da_sample;
  logic                   ts_bit;
  logic                   ss_bit;
  logic                   int_req;
  tone_pkg::vec_addr_t    int_vec;
  tone_pkg::pcm_out_t     pcm_out;

  // model state, as it stands after the last clock
  int                     m_count;
  tone_pkg::tone_period_t m_n;
  tone_pkg::tone_period_t m_nc;
  tone_pkg::nuc_count_t   m_nuc;
  logic                   m_reload_d;
  logic                   m_cond_d;
  logic                   m_trig;
  logic                   m_pending;
  logic                   m_active;
  tone_pkg::pcm_out_t     m_pcm;

  int                     errors;
  int                     req_count;
  int                     reti_wait;
  logic                   await_reti;  // request seen, no reti yet
  logic                   load_req;
  tone_pkg::tone_period_t load_val;

  task automatic stop_run();
    errors++;
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_checks.svh"

  tone_sound_top #(
    .PHASE_STEPS (PHASE_STEPS)
  ) tone_sound_top_inst (
    .CLK       (CLK),
    .reset     (reset),
    .cken      (cken),
    .n_load    (n_load),
    .n_value   (n_value),
    .tone_ie   (tone_ie),
    .reti      (reti),
    .da_write  (da_write),
    .da_sample (da_sample),
    .ts_bit    (ts_bit),
    .ss_bit    (ss_bit),
    .int_req   (int_req),
    .int_vec   (int_vec),
    .pcm_out   (pcm_out)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic int range_index(input tone_pkg::tone_period_t n);
    if (n < 8'h08) return 0;
    if (n < 8'h10) return 1;
    if (n < 8'h20) return 2;
    if (n < 8'h40) return 3;
    return 4;
  endfunction

  function automatic tone_pkg::vec_addr_t expected_vec(input tone_pkg::tone_period_t n);
    int idx;
    int offs;
    idx  = range_index(n);
    offs = (idx <= 1) ? 0 : (idx - 1) * tone_pkg::RANGE_VEC_STEP;  // 08-0f shares base
    return tone_pkg::TONE_VEC_BASE + tone_pkg::vec_addr_t'(offs);
  endfunction

  function automatic tone_pkg::tone_period_t pick_in_range(input int r);
    int lo;
    int hi;
    case (r)
      0: begin
        lo = 8'h00;
        hi = 8'h07;
      end
      1: begin
        lo = 8'h08;
        hi = 8'h0f;
      end
      2: begin
        lo = 8'h10;
        hi = 8'h1f;
      end
      3: begin
        lo = 8'h20;
        hi = 8'h3f;
      end
      default: begin
        lo = 8'h40;
        hi = 8'hff;
      end
    endcase
    return tone_pkg::tone_period_t'(lo + int'($urandom % (hi - lo + 1)));
  endfunction

  //////////////////////////////////////////////////
  // stimulus, one cycle, at the falling edge

  task automatic drive_inputs(input int mode);
    cken      = 1'b1;
    tone_ie   = 1'b0;
    reti      = 1'b0;
    da_write  = 1'b0;
    n_value   = tone_pkg::tone_period_t'($urandom);
    da_sample = tone_pkg::pcm_sample_t'($urandom);
    ts_bit    = ($urandom % 2) == 1;
    ss_bit    = ($urandom % 2) == 1;
    case (mode)
      MODE_RANGE: tone_ie = 1'b1;
      MODE_RANDOM: begin
        cken     = ($urandom % 100) < 80;
        tone_ie  = ($urandom % 100) < 90;
        reti     = ($urandom % 100) < 3;
        da_write = ($urandom % 100) < 5;
        if (($urandom % 400) == 0) begin  // occasional N reload
          load_req = 1'b1;
          load_val = tone_pkg::tone_period_t'($urandom);
        end
      end
      MODE_DAC: begin
        cken     = ($urandom % 100) < 80;
        da_write = ($urandom % 100) < 25;
      end
      default: ;
    endcase
    if (mode == MODE_RANGE && reti_wait > 0) begin
      reti_wait--;
      reti = (reti_wait == 0);  // return some steps after the request
    end
    n_load = load_req;
    if (load_req) n_value = load_val;
  endtask

  //////////////////////////////////////////////////
  // compare outputs, then move the model one clock

  task automatic check_and_advance(input int mode);
    logic tick;
    logic cp2;
    logic cond;
    logic ret;
    logic req;
    logic set_pend;
    logic nc_is_1;
    tick = cken && (m_count == PHASE_STEPS - 1);
    cp2  = (m_count >= 2) && (m_count <= 5);
    case (range_index(m_n))
      1:       cond = m_nuc[2];
      2:       cond = m_nuc[1];
      3:       cond = m_nuc[0];
      4:       cond = m_reload_d;
      default: cond = 1'b0;
    endcase
    ret = cken && reti;
    req = tick && m_pending && !m_active && !ret;
    check_req("int_req", req, int_req);
    check_vec("int_vec", expected_vec(m_n), int_vec);
    check_pcm("pcm_out", m_pcm, pcm_out);
    if (int_req) begin
      if (await_reti) report_problem("a second tone request came before any reti");
      await_reti = 1'b1;
      req_count++;
      if (mode == MODE_RANGE) reti_wait = 1 + int'($urandom % 16);
    end
    if (ret) await_reti = 1'b0;
    set_pend = cken && cp2 && m_trig && tone_ie && !m_active;
    if (cken) m_count = (m_count == PHASE_STEPS - 1) ? 0 : m_count + 1;
    if (tick) begin
      nc_is_1 = (m_nc == 8'd1);
      if (m_reload_d) m_nuc = m_nuc + 3'd1;
      m_reload_d = nc_is_1;
      m_nc       = nc_is_1 ? m_n : m_nc - 8'd1;
      m_trig     = m_cond_d && !cond;  // falling edge of the condition
      m_cond_d   = cond;
    end
    if (req) begin
      m_active  = 1'b1;
      m_pending = 1'b0;
    end else if (set_pend) begin
      m_pending = 1'b1;
    end
    if (ret) m_active = 1'b0;
    if (cken && n_load) begin
      m_n      = n_value;
      load_req = 1'b0;
    end
    if (cken && da_write) m_pcm = {ss_bit, ts_bit ? ~da_sample : da_sample};
  endtask

  task automatic run_cycles(input int count, input int mode);
    repeat (count) begin
      drive_inputs(mode);
      #1;
      check_and_advance(mode);
      @(negedge CLK);
    end
  endtask

  initial begin
    int quiet_n[3];
    CLK = 1'b0;
    reset = 1'b1;
    cken = 1'b0;
    n_load = 1'b0;
    n_value = '0;
    tone_ie = 1'b0;
    reti = 1'b0;
    da_write = 1'b0;
    da_sample = '0;
    ts_bit = 1'b0;
    ss_bit = 1'b0;
    m_count = 0;
    m_n = '0;
    m_nc = '0;
    m_nuc = '0;
    m_reload_d = 1'b0;
    m_cond_d = 1'b0;
    m_trig = 1'b0;
    m_pending = 1'b0;
    m_active = 1'b0;
    m_pcm = '0;
    errors = 0;
    req_count = 0;
    reti_wait = 0;
    await_reti = 1'b0;
    load_req = 1'b0;
    load_val = '0;
    quiet_n = '{1, 2, 5};
    void'($urandom(32'h4c1a0546));
    repeat (RESET_CYCLES) @(negedge CLK);
    reset = 1'b0;

    // no requests while the tone interrupt is disabled
    foreach (quiet_n[i]) begin
      load_req  = 1'b1;
      load_val  = tone_pkg::tone_period_t'(quiet_n[i]);
      req_count = 0;
      run_cycles(QUIET_CYCLES, MODE_QUIET);
      if (req_count != 0) report_problem("int_req rose while tone_ie was low");
    end

    // one N per range, lowest range first
    for (int r = 0; r < 5; r++) begin
      load_req  = 1'b1;
      load_val  = pick_in_range(r);
      req_count = 0;
      run_cycles(RANGE_CYCLES, MODE_RANGE);
      if (r == 0 && req_count != 0) report_problem("the lowest N range raised a request");
      if (r != 0 && req_count == 0) report_problem("no tone request seen for an N range");
    end

    run_cycles(RANDOM_CYCLES, MODE_RANDOM);
    run_cycles(DAC_CYCLES, MODE_DAC);

    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("the run timed out after %0d clock periods", 2 * TOTAL_CYCLES);
    stop_run();
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the tone sound testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_tone_sound -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- src/dac_output.sv
//////////////////////////////////////////////////
// DAC sample register and conversion of the DA
// word to a 9 bit two's complement PCM value
// written by the da_write strobe, holds until the
// next write
//////////////////////////////////////////////////

module dac_output (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  cken,
  input  logic                  da_write,
  input  tone_pkg::pcm_sample_t da_sample,
  input  logic                  ts_bit,
  input  logic                  ss_bit,
  output tone_pkg::pcm_out_t    pcm_out
);

  typedef struct packed {
    logic                  inv;     // ss xor ts
    logic                  sign;    // ss
    tone_pkg::pcm_sample_t sample;
  } da_word_t;

  da_word_t              da;
  tone_pkg::pcm_sample_t dac_in;

  always_ff @(posedge CLK) begin
    if (reset) begin
      da <= '0;
    end else if (cken && da_write) begin
      da <= '{inv: ss_bit ^ ts_bit, sign: ss_bit, sample: da_sample};
    end
  end

  assign dac_in = da.inv ? ~da.sample : da.sample;  // DAC input stage

  // negative half folds back into two's complement
  assign pcm_out = {da.sign, (da.sign ? ~dac_in : dac_in)};

endmodule

//--- src/irq_controller.sv
//////////////////////////////////////////////////
// single source interrupt controller for the tone
// trigger: pending bit set in the cp2 window,
// request pulse on the next tick, vector from the
// range of N, cleared by a return strobe
//////////////////////////////////////////////////

module irq_controller (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     cken,
  input  tone_pkg::phase_strobes_t phase,
  input  logic                     tone_trig,
  input  tone_pkg::n_range_e       range,
  input  logic                     tone_ie,
  input  logic                     reti,
  output logic                     int_req,
  output tone_pkg::vec_addr_t      int_vec
);

  tone_pkg::irq_state_e state;
  logic                 pending;
  logic                 set_pend;
  logic                 go_active;
  logic                 ret_step;
  logic [1:0]           vec_idx;

  assign ret_step  = cken & reti;
  assign set_pend  = cken & phase.cp2_win & tone_trig & tone_ie & (state == tone_pkg::IRQ_IDLE);
  // return strobe wins over a new activation
  assign go_active = phase.tick & pending & (state == tone_pkg::IRQ_IDLE) & ~ret_step;

  //////////////////////////////////////////////////
  // state and pending

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= tone_pkg::IRQ_IDLE;
      pending <= 1'b0;
    end else begin
      if (go_active) begin
        state   <= tone_pkg::IRQ_ACTIVE;
        pending <= 1'b0;
      end else if (set_pend) begin
        pending <= 1'b1;
      end
      if (ret_step) begin
        state <= tone_pkg::IRQ_IDLE;
      end
    end
  end

  assign int_req = go_active;  // one clock, in the tick step

  //////////////////////////////////////////////////
  // vector

  always_comb begin
    case (range)
      tone_pkg::RANGE_10_1F: vec_idx = 2'd1;
      tone_pkg::RANGE_20_3F: vec_idx = 2'd2;
      tone_pkg::RANGE_40_FF: vec_idx = 2'd3;
      default:               vec_idx = 2'd0;
    endcase
  end

  assign int_vec = tone_pkg::TONE_VEC_BASE
                 + tone_pkg::vec_addr_t'(tone_pkg::RANGE_VEC_STEP) * tone_pkg::vec_addr_t'(vec_idx);

  // a pending request only ever waits in the idle state
  a_pending_idle: assert property (@(posedge CLK) disable iff (reset)
    pending |-> (state == tone_pkg::IRQ_IDLE));

endmodule

//--- src/phase_sequencer.sv
//////////////////////////////////////////////////
// step counter that splits the clock enable into
// machine cycles of PHASE_STEPS steps
// gives a tick on the last step and a registered
// cp2 window on steps 2 to 5 of each cycle
//////////////////////////////////////////////////

module phase_sequencer #(
  parameter int PHASE_STEPS = 8
) (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    cken,
  output tone_pkg::phase_strobes_t phase
);

  localparam int CW        = $clog2(PHASE_STEPS);
  localparam int CP2_FIRST = 2;
  localparam int CP2_LAST  = 5;

  logic [CW-1:0] count;
  logic [CW-1:0] count_nxt;
  logic          last_step;
  logic          cp2_win_q;

  assign last_step = (count == CW'(PHASE_STEPS - 1));
  assign count_nxt = last_step ? '0 : count + 1'b1;

  always_ff @(posedge CLK) begin
    if (reset) begin
      count     <= '0;
      cp2_win_q <= 1'b0;
    end else if (cken) begin
      count     <= count_nxt;
      // window follows the count it will hold
      cp2_win_q <= (int'(count_nxt) >= CP2_FIRST) && (int'(count_nxt) <= CP2_LAST);
    end
  end

  assign phase.tick    = cken & last_step;  // only on a real step
  assign phase.cp2_win = cp2_win_q;

  // the tick step never falls inside the cp2 window
  a_tick_outside_cp2: assert property (@(posedge CLK) disable iff (reset)
    phase.tick |-> !phase.cp2_win);

endmodule

//--- src/tone_divider.sv
//////////////////////////////////////////////////
// tone divider: N reload register, NC down counter
// and NUC reload counter, all advanced on ticks
// also classifies N into its range for the
// interrupt condition select
//////////////////////////////////////////////////

module tone_divider (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     cken,
  input  tone_pkg::phase_strobes_t phase,
  input  logic                     n_load,
  input  tone_pkg::tone_period_t   n_value,
  output tone_pkg::tone_state_t    state
);

  tone_pkg::tone_period_t n;
  tone_pkg::tone_period_t nc;
  tone_pkg::nuc_count_t   nuc;
  tone_pkg::n_range_e     n_range;
  logic                   nc_eq_01;
  logic                   nc_reload_d;

  assign nc_eq_01 = (nc == 8'd1);  // reload point

  // N is written by the CPU side strobe
  always_ff @(posedge CLK) begin
    if (reset) begin
      n <= '0;
    end else if (cken && n_load) begin
      n <= n_value;
    end
  end

  //////////////////////////////////////////////////
  // NC / NUC counters

  always_ff @(posedge CLK) begin
    if (reset) begin
      nc          <= '0;
      nuc         <= '0;
      nc_reload_d <= 1'b0;
    end else if (cken && phase.tick) begin
      if (nc_eq_01) begin
        nc <= n;
      end else begin
        nc <= nc - 1'b1;  // wraps 0 -> ff
      end
      nc_reload_d <= nc_eq_01;
      if (nc_reload_d) begin
        nuc <= nuc + 1'b1;  // one count per reload
      end
    end
  end

  always_comb begin
    if (n < 8'h08) begin
      n_range = tone_pkg::RANGE_00_07;
    end else if (n < 8'h10) begin
      n_range = tone_pkg::RANGE_08_0F;
    end else if (n < 8'h20) begin
      n_range = tone_pkg::RANGE_10_1F;
    end else if (n < 8'h40) begin
      n_range = tone_pkg::RANGE_20_3F;  // 3f included
    end else begin
      n_range = tone_pkg::RANGE_40_FF;
    end
  end

  assign state.nc_reload_d = nc_reload_d;
  assign state.nuc         = nuc;
  assign state.range       = n_range;

  // NC only lands on 0 through a reload of N = 0
  a_nc_nonzero: assert property (@(posedge CLK) disable iff (reset)
    (cken && phase.tick) |=> (nc != '0) || ($past(n) == '0));

endmodule

//--- src/tone_irq_detect.sv
//////////////////////////////////////////////////
// tone interrupt trigger: picks the condition that
// matches the range of N and flags its falling
// edge, one tick period long
//////////////////////////////////////////////////

module tone_irq_detect (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  cken,
  input  logic                  tick,
  input  tone_pkg::tone_state_t state,
  output logic                  tone_trig,
  output tone_pkg::n_range_e    range
);

  logic tone_cond;
  logic tone_cond_d;

  // slower tones use higher NUC bits
  always_comb begin
    case (state.range)
      tone_pkg::RANGE_08_0F: tone_cond = state.nuc[2];
      tone_pkg::RANGE_10_1F: tone_cond = state.nuc[1];
      tone_pkg::RANGE_20_3F: tone_cond = state.nuc[0];
      tone_pkg::RANGE_40_FF: tone_cond = state.nc_reload_d;
      default:               tone_cond = 1'b0;  // 00-07 never fires
    endcase
  end

  //////////////////////////////////////////////////
  // falling edge detect, sampled per tick

  always_ff @(posedge CLK) begin
    if (reset) begin
      tone_cond_d <= 1'b0;
      tone_trig   <= 1'b0;
    end else if (cken && tick) begin
      tone_cond_d <= tone_cond;
      tone_trig   <= tone_cond_d & ~tone_cond;  // 1 -> 0
    end
  end

  assign range = state.range;  // vector select downstream

endmodule

//--- src/tone_pkg.sv
//////////////////////////////////////////////////
// shared types and constants for the tone sound
// path: phase strobes, divider state, N ranges,
// interrupt state and vector constants
// referenced by scoped name from every module
//////////////////////////////////////////////////

package tone_pkg;

  //////////////////////////////////////////////////
  // plain vector types

  typedef logic [7:0]  tone_period_t;  // N and NC
  typedef logic [2:0]  nuc_count_t;    // NC reload counter
  typedef logic [7:0]  pcm_sample_t;   // raw DAC sample
  typedef logic [8:0]  pcm_out_t;      // two's complement PCM
  typedef logic [11:0] vec_addr_t;     // interrupt vector address

  //////////////////////////////////////////////////
  // enums

  // range of N, picks the tone interrupt source
  typedef enum logic [2:0] {
    RANGE_00_07 = 3'd0,
    RANGE_08_0F = 3'd1,
    RANGE_10_1F = 3'd2,
    RANGE_20_3F = 3'd3,
    RANGE_40_FF = 3'd4
  } n_range_e;

  typedef enum logic {
    IRQ_IDLE   = 1'b0,
    IRQ_ACTIVE = 1'b1
  } irq_state_e;

  //////////////////////////////////////////////////
  // bundles between stages

  typedef struct packed {
    logic tick;     // one step in eight
    logic cp2_win;  // second phase window
  } phase_strobes_t;

  typedef struct packed {
    logic       nc_reload_d;  // NC was 1 on last tick
    nuc_count_t nuc;
    n_range_e   range;
  } tone_state_t;

  //////////////////////////////////////////////////
  // vector constants

  localparam vec_addr_t TONE_VEC_BASE  = 12'h020;
  localparam int        RANGE_VEC_STEP = 4;  // offset per range step

endpackage

//--- src/tone_sound_top.sv
//////////////////////////////////////////////////
// top level of the tone sound path: phase
// sequencer, tone divider, trigger detect and
// interrupt controller in a chain, DAC output on
// its own branch
//////////////////////////////////////////////////

module tone_sound_top #(
  parameter int PHASE_STEPS = 8
) (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   cken,
  input  logic                   n_load,
  input  tone_pkg::tone_period_t n_value,
  input  logic                   tone_ie,
  input  logic                   reti,
  input  logic                   da_write,
  input  tone_pkg::pcm_sample_t  da_sample,
  input  logic                   ts_bit,
  input  logic                   ss_bit,
  output logic                   int_req,
  output tone_pkg::vec_addr_t    int_vec,
  output tone_pkg::pcm_out_t     pcm_out
);

  tone_pkg::phase_strobes_t phase;
  tone_pkg::tone_state_t    tone_state;
  tone_pkg::n_range_e       range;
  logic                     tone_trig;

  phase_sequencer #(
    .PHASE_STEPS (PHASE_STEPS)
  ) phase_sequencer_inst (
    .CLK   (CLK),
    .reset (reset),
    .cken  (cken),
    .phase (phase)
  );

  tone_divider tone_divider_inst (
    .CLK     (CLK),
    .reset   (reset),
    .cken    (cken),
    .phase   (phase),
    .n_load  (n_load),
    .n_value (n_value),
    .state   (tone_state)
  );

  tone_irq_detect tone_irq_detect_inst (
    .CLK       (CLK),
    .reset     (reset),
    .cken      (cken),
    .tick      (phase.tick),
    .state     (tone_state),
    .tone_trig (tone_trig),
    .range     (range)
  );

  irq_controller irq_controller_inst (
    .CLK       (CLK),
    .reset     (reset),
    .cken      (cken),
    .phase     (phase),
    .tone_trig (tone_trig),
    .range     (range),
    .tone_ie   (tone_ie),
    .reti      (reti),
    .int_req   (int_req),
    .int_vec   (int_vec)
  );

  dac_output dac_output_inst (
    .CLK       (CLK),
    .reset     (reset),
    .cken      (cken),
    .da_write  (da_write),
    .da_sample (da_sample),
    .ts_bit    (ts_bit),
    .ss_bit    (ss_bit),
    .pcm_out   (pcm_out)
  );

endmodule

//--- verilog.f
+incdir+dv
src/tone_pkg.sv
src/phase_sequencer.sv
src/tone_divider.sv
src/tone_irq_detect.sv
src/irq_controller.sv
src/dac_output.sv
src/tone_sound_top.sv
dv/tb_tone_sound.sv
